//--- design/rv_pkg.sv
package rv_pkg;

    // word width, also the instruction width
    parameter int XLEN = 32;

    // major opcodes of the supported subset
    typedef enum logic [6:0] {
        opc_op     = 7'b0110011,
        opc_op_imm = 7'b0010011,
        opc_load   = 7'b0000011,
        opc_store  = 7'b0100011,
        opc_branch = 7'b1100011,
        opc_lui    = 7'b0110111,
        opc_auipc  = 7'b0010111,
        opc_jal    = 7'b1101111
    } opcode_e;

    // alu operation codes
    // low three bits follow funct3 where possible
    typedef enum logic [3:0] {
        alu_add    = 4'b0000,
        alu_sll    = 4'b0001,
        alu_slt    = 4'b0010,
        alu_sltu   = 4'b0011,
        alu_xor    = 4'b0100,
        alu_srl    = 4'b0101,
        alu_or     = 4'b0110,
        alu_and    = 4'b0111,
        alu_sub    = 4'b1000,
        alu_sra    = 4'b1101,
        alu_pass_b = 4'b1111
    } alu_op_e;

    // first alu operand
    typedef enum logic [1:0] {
        a_rs1  = 2'd0,
        a_pc   = 2'd1,
        a_zero = 2'd2
    } a_sel_e;

    // register write-back source
    typedef enum logic [1:0] {
        wb_alu  = 2'd0,
        wb_load = 2'd1,
        wb_link = 2'd2
    } wb_sel_e;

endpackage

//--- design/instr_decoder.sv
`timescale 1ns/1ps

module instr_decoder (
    input  logic [rv_pkg::XLEN-1:0] instr,
    output logic                    reg_write,
    output logic                    mem_write,
    output logic                    alu_src_imm,
    output logic                    branch,
    output logic                    jump,
    output rv_pkg::a_sel_e          a_sel,
    output rv_pkg::wb_sel_e         wb_sel,
    output rv_pkg::alu_op_e         alu_op,
    output logic [rv_pkg::XLEN-1:0] imm
);
    import rv_pkg::*;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic       bit30;

    // instruction fields
    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign bit30  = instr[30];

    // funct3 to alu op, alt picks sub or sra
    function automatic alu_op_e arith_op(input logic [2:0] f3, input logic alt);
        case (f3)
            3'b000:  return alt ? alu_sub : alu_add;
            3'b001:  return alu_sll;
            3'b010:  return alu_slt;
            3'b011:  return alu_sltu;
            3'b100:  return alu_xor;
            3'b101:  return alt ? alu_sra : alu_srl;
            3'b110:  return alu_or;
            default: return alu_and;
        endcase
    endfunction

    // main control
    always_comb begin
        // defaults give no writes for unknown opcodes
        reg_write   = 1'b0;
        mem_write   = 1'b0;
        alu_src_imm = 1'b0;
        branch      = 1'b0;
        jump        = 1'b0;
        a_sel       = a_rs1;
        wb_sel      = wb_alu;
        case (opcode)
            opc_op: begin
                reg_write = 1'b1;
            end
            opc_op_imm: begin
                reg_write   = 1'b1;
                alu_src_imm = 1'b1;
            end
            opc_load: begin
                reg_write   = 1'b1;
                alu_src_imm = 1'b1;
                wb_sel      = wb_load;
            end
            opc_store: begin
                mem_write   = 1'b1;
                alu_src_imm = 1'b1;
            end
            opc_branch: begin
                // rs1 - rs2 feeds the zero flag
                branch = 1'b1;
            end
            opc_lui: begin
                reg_write   = 1'b1;
                alu_src_imm = 1'b1;
                a_sel       = a_zero;
            end
            opc_auipc: begin
                reg_write   = 1'b1;
                alu_src_imm = 1'b1;
                a_sel       = a_pc;
            end
            opc_jal: begin
                // link value comes from pc+4, not the alu
                reg_write = 1'b1;
                jump      = 1'b1;
                wb_sel    = wb_link;
            end
            default: begin
                reg_write = 1'b0;
            end
        endcase
    end

    // alu control
    always_comb begin
        case (opcode)
            opc_op:     alu_op = arith_op(funct3, bit30);
            // bit 30 is an immediate bit except for srai
            opc_op_imm: alu_op = arith_op(funct3, bit30 && funct3 == 3'b101);
            opc_branch: alu_op = alu_sub;
            opc_jal:    alu_op = alu_pass_b;
            default:    alu_op = alu_add;
        endcase
    end

    // immediate by format
    always_comb begin
        case (opcode)
            opc_store:
                imm = {{(XLEN-12){instr[31]}}, instr[31:25], instr[11:7]};
            opc_branch:
                imm = {{(XLEN-13){instr[31]}}, instr[31], instr[7], instr[30:25],
                       instr[11:8], 1'b0};
            opc_lui, opc_auipc:
                imm = {instr[31:12], 12'b0};
            opc_jal:
                imm = {{(XLEN-21){instr[31]}}, instr[31], instr[19:12], instr[20],
                       instr[30:21], 1'b0};
            // i format for alu immediates and loads
            default:
                imm = {{(XLEN-12){instr[31]}}, instr[31:20]};
        endcase
    end

endmodule

//--- design/register_file.sv
`timescale 1ns/1ps

module register_file (
    input  logic                    CLK,
    input  logic                    RESET_N,
    input  logic [4:0]              rs1_addr,
    input  logic [4:0]              rs2_addr,
    input  logic [4:0]              rd_addr,
    input  logic [rv_pkg::XLEN-1:0] rd_data,
    input  logic                    wr_en,
    output logic [rv_pkg::XLEN-1:0] rs1_data,
    output logic [rv_pkg::XLEN-1:0] rs2_data
);
    import rv_pkg::*;

    // x0 included, never written after reset
    logic [XLEN-1:0] regs [32];

    // write port
    always_ff @(posedge CLK or negedge RESET_N) begin
        if (!RESET_N) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && rd_addr != 5'd0) begin
            // writes to x0 dropped here
            regs[rd_addr] <= rd_data;
        end
    end

    // two combinational read ports
    assign rs1_data = regs[rs1_addr];
    assign rs2_data = regs[rs2_addr];

endmodule

//--- design/alu.sv
`timescale 1ns/1ps

module alu #(
    parameter int ADDR_WIDTH = 10
) (
    input  logic [rv_pkg::XLEN-1:0] rs1_data,
    input  logic [rv_pkg::XLEN-1:0] rs2_data,
    input  logic [rv_pkg::XLEN-1:0] imm,
    input  logic [ADDR_WIDTH+1:0]   pc,
    input  rv_pkg::a_sel_e          a_sel,
    input  logic                    alu_src_imm,
    input  rv_pkg::alu_op_e         alu_op,
    output logic [rv_pkg::XLEN-1:0] result,
    output logic                    zero
);
    import rv_pkg::*;

    logic [XLEN-1:0] op_a;
    logic [XLEN-1:0] op_b;
    logic [4:0]      shamt;

    // first operand
    always_comb begin
        case (a_sel)
            a_rs1:   op_a = rs1_data;
            // byte pc, zero-extended
            a_pc:    op_a = {{(XLEN-ADDR_WIDTH-2){1'b0}}, pc};
            default: op_a = '0;
        endcase
    end

    // second operand
    assign op_b  = alu_src_imm ? imm : rs2_data;
    // only the low five bits shift
    assign shamt = op_b[4:0];

    always_comb begin
        case (alu_op)
            alu_add:    result = op_a + op_b;
            alu_sub:    result = op_a - op_b;
            alu_sll:    result = op_a << shamt;
            alu_slt:    result = {{(XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
            alu_sltu:   result = {{(XLEN-1){1'b0}}, op_a < op_b};
            alu_xor:    result = op_a ^ op_b;
            alu_srl:    result = op_a >> shamt;
            alu_sra:    result = $unsigned($signed(op_a) >>> shamt);
            alu_or:     result = op_a | op_b;
            alu_and:    result = op_a & op_b;
            alu_pass_b: result = op_b;
            default:    result = '0;
        endcase
    end

    // beq/bne compare through rs1 - rs2
    assign zero = (result == '0);

endmodule

//--- design/pc_unit.sv
`timescale 1ns/1ps

module pc_unit #(
    parameter int ADDR_WIDTH = 10
) (
    input  logic                    CLK,
    input  logic                    RESET_N,
    input  logic [rv_pkg::XLEN-1:0] imm,
    input  logic                    branch,
    input  logic                    jump,
    input  logic                    branch_ne,
    input  logic                    zero,
    output logic [ADDR_WIDTH+1:0]   pc,
    output logic [ADDR_WIDTH+1:0]   pc_plus4
);
    import rv_pkg::*;

    logic [ADDR_WIDTH+1:0] target;
    logic [ADDR_WIDTH+1:0] next_pc;
    logic                  taken;

    // sequential address
    assign pc_plus4 = pc + (ADDR_WIDTH+2)'(4);

    // pc-relative target, upper imm bits fall outside memory
    assign target = pc + imm[ADDR_WIDTH+1:0];

    // beq wants zero, bne wants not zero
    assign taken = jump || (branch && (zero ^ branch_ne));

    assign next_pc = taken ? target : pc_plus4;

    // byte program counter
    always_ff @(posedge CLK or negedge RESET_N) begin
        if (!RESET_N) begin
            pc <= '0;
        end else begin
            pc <= next_pc;
        end
    end

endmodule

//--- design/rv_core.sv
`timescale 1ns/1ps

module rv_core #(
    parameter int ADDR_WIDTH = 10
) (
    input  logic                    CLK,
    input  logic                    RESET_N,
    input  logic [rv_pkg::XLEN-1:0] idata,
    input  logic [rv_pkg::XLEN-1:0] ddata_r,
    output logic [ADDR_WIDTH-1:0]   iaddr,
    output logic [ADDR_WIDTH-1:0]   daddr,
    output logic [rv_pkg::XLEN-1:0] ddata_w,
    output logic                    d_rw
);
    import rv_pkg::*;

    // decoder controls
    logic    reg_write;
    logic    mem_write;
    logic    alu_src_imm;
    logic    branch;
    logic    jump;
    a_sel_e  a_sel;
    wb_sel_e wb_sel;
    alu_op_e alu_op;

    logic [XLEN-1:0]       imm;
    logic [XLEN-1:0]       rs1_data;
    logic [XLEN-1:0]       rs2_data;
    logic [XLEN-1:0]       alu_result;
    logic                  alu_zero;
    logic [XLEN-1:0]       wb_data;
    logic [ADDR_WIDTH+1:0] pc;
    logic [ADDR_WIDTH+1:0] pc_plus4;

    instr_decoder instr_decoder_inst (
        .instr       (idata),
        .reg_write   (reg_write),
        .mem_write   (mem_write),
        .alu_src_imm (alu_src_imm),
        .branch      (branch),
        .jump        (jump),
        .a_sel       (a_sel),
        .wb_sel      (wb_sel),
        .alu_op      (alu_op),
        .imm         (imm)
    );

    // register fields read alongside decode
    register_file register_file_inst (
        .CLK      (CLK),
        .RESET_N  (RESET_N),
        .rs1_addr (idata[19:15]),
        .rs2_addr (idata[24:20]),
        .rd_addr  (idata[11:7]),
        .rd_data  (wb_data),
        .wr_en    (reg_write),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data)
    );

    alu #(.ADDR_WIDTH(ADDR_WIDTH)) alu_inst (
        .rs1_data    (rs1_data),
        .rs2_data    (rs2_data),
        .imm         (imm),
        .pc          (pc),
        .a_sel       (a_sel),
        .alu_src_imm (alu_src_imm),
        .alu_op      (alu_op),
        .result      (alu_result),
        .zero        (alu_zero)
    );

    // funct3 bit 0 tells bne from beq
    pc_unit #(.ADDR_WIDTH(ADDR_WIDTH)) pc_unit_inst (
        .CLK       (CLK),
        .RESET_N   (RESET_N),
        .imm       (imm),
        .branch    (branch),
        .jump      (jump),
        .branch_ne (idata[12]),
        .zero      (alu_zero),
        .pc        (pc),
        .pc_plus4  (pc_plus4)
    );

    // write-back select
    always_comb begin
        case (wb_sel)
            wb_load: wb_data = ddata_r;
            wb_link: wb_data = {{(XLEN-ADDR_WIDTH-2){1'b0}}, pc_plus4};
            default: wb_data = alu_result;
        endcase
    end

    // word addresses for both memories
    assign iaddr   = pc[ADDR_WIDTH+1:2];
    assign daddr   = alu_result[ADDR_WIDTH+1:2];
    assign ddata_w = rs2_data;
    assign d_rw    = mem_write;

endmodule

//--- tests/register_file_assertions.sv
`timescale 1ns/1ps

module register_file_assertions (
    input logic                    CLK,
    input logic                    RESET_N,
    input logic [4:0]              rs1_addr,
    input logic [4:0]              rs2_addr,
    input logic [4:0]              rd_addr,
    input logic [rv_pkg::XLEN-1:0] rd_data,
    input logic                    wr_en,
    input logic [rv_pkg::XLEN-1:0] rs1_data,
    input logic [rv_pkg::XLEN-1:0] rs2_data
);

    // count of failed assertions
    int fail_count = 0;

    // x0 reads zero on both ports
    assert property (@(posedge CLK) rs1_addr == 5'd0 |-> rs1_data == '0)
        else begin
            fail_count++;
            $error("x0 read on port 1 is not zero");
        end
    assert property (@(posedge CLK) rs2_addr == 5'd0 |-> rs2_data == '0)
        else begin
            fail_count++;
            $error("x0 read on port 2 is not zero");
        end

    // last cycle's write visible now, reset edge excluded
    assert property (@(posedge CLK) disable iff (!RESET_N)
        $past(RESET_N) && $past(wr_en) && $past(rd_addr) != 5'd0
            && rs1_addr == $past(rd_addr) |-> rs1_data == $past(rd_data))
        else begin
            fail_count++;
            $error("written register not read back on port 1");
        end

    // cleared while in reset, from the second edge in reset on
    assert property (@(posedge CLK)
        !RESET_N && $past(!RESET_N) |-> rs1_data == '0 && rs2_data == '0)
        else begin
            fail_count++;
            $error("register read not zero during reset");
        end

endmodule

bind register_file register_file_assertions register_file_assertions_inst (
    .CLK      (CLK),
    .RESET_N  (RESET_N),
    .rs1_addr (rs1_addr),
    .rs2_addr (rs2_addr),
    .rd_addr  (rd_addr),
    .rd_data  (rd_data),
    .wr_en    (wr_en),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data)
);

//--- tests/tb_rv_core.sv
`timescale 1ns/1ps

module tb_rv_core;
    import rv_pkg::*;

    localparam int ADDR_WIDTH   = 10;
    localparam int DEPTH        = 1 << ADDR_WIDTH;
    localparam int RESET_CYCLES = 5;
    localparam int EXP_WIDTH    = 2 * ADDR_WIDTH + XLEN + 1;

    logic                  CLK = 1'b0;
    logic                  RESET_N;
    logic [XLEN-1:0]       idata;
    logic [XLEN-1:0]       ddata_r;
    logic [XLEN-1:0]       ddata_w;
    logic [ADDR_WIDTH-1:0] iaddr;
    logic [ADDR_WIDTH-1:0] daddr;
    logic                  d_rw;

    // environment memories
    logic [XLEN-1:0] imem [DEPTH];
    logic [XLEN-1:0] dmem [DEPTH];

    // architectural model
    logic [XLEN-1:0] m_reg [32];
    logic [XLEN-1:0] m_dmem [DEPTH];
    logic [XLEN-1:0] m_pc;

    // step waiting for the next rising edge
    logic [XLEN-1:0]       nxt_pc;
    logic [XLEN-1:0]       nxt_val;
    logic [XLEN-1:0]       st_data;
    logic [4:0]            nxt_rd;
    logic                  nxt_wr;
    logic                  nxt_st;
    logic                  addr_used;
    logic [ADDR_WIDTH-1:0] st_word;

    integer          seed;
    int              prog_len;
    int              exec_est;
    int              st_addr;
    int              limit;
    int              cycles;
    int              rf_fails;
    logic [XLEN-1:0] final_pc;
    logic            done;
    logic            have_step;

    rv_core #(.ADDR_WIDTH(ADDR_WIDTH)) rv_core_inst (
        .CLK     (CLK),
        .RESET_N (RESET_N),
        .idata   (idata),
        .ddata_r (ddata_r),
        .iaddr   (iaddr),
        .daddr   (daddr),
        .ddata_w (ddata_w),
        .d_rw    (d_rw)
    );

    // 40 ns period
    always #20 CLK = ~CLK;

    // both memories answer in the same cycle
    assign idata   = imem[iaddr];
    assign ddata_r = dmem[daddr];

    // failed register file assertions so far
    assign rf_fails = rv_core_inst.register_file_inst.register_file_assertions_inst.fail_count;

    always @(posedge CLK) begin
        if (d_rw) begin
            dmem[daddr] <= ddata_w;
        end
    end

    // initial data memory contents, every address bit counts
    function automatic logic [XLEN-1:0] fill_word(input int i);
        return {i[15:0], ~i[15:0]} ^ 32'h5a3c_96e1;
    endfunction

    // instruction formats
    function automatic logic [31:0] r_type(input logic [2:0] f3, input logic alt,
                                           input logic [4:0] rd, input logic [4:0] rs1,
                                           input logic [4:0] rs2);
        return {1'b0, alt, 5'b0, rs2, rs1, f3, rd, opc_op};
    endfunction

    function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                           input logic [2:0] f3, input logic [4:0] rd,
                                           input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] s_type(input logic [11:0] imm, input logic [4:0] rs2,
                                           input logic [4:0] rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], opc_store};
    endfunction

    function automatic logic [31:0] b_type(input logic [12:0] imm, input logic [4:0] rs1,
                                           input logic [4:0] rs2, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], opc_branch};
    endfunction

    function automatic logic [31:0] u_type(input logic [19:0] imm, input logic [4:0] rd,
                                           input logic [6:0] opc);
        return {imm, rd, opc};
    endfunction

    function automatic logic [31:0] j_type(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, opc_jal};
    endfunction

    task automatic emit(input logic [31:0] w);
        imem[prog_len] = w;
        prog_len++;
        exec_est++;
    endtask

    // sw to the next free word, base x0
    task automatic store_word(input logic [4:0] rs2);
        emit(s_type(st_addr[11:0], rs2, 5'd0));
        st_addr += 4;
    endtask

    task automatic build_program();
        logic [3:0]  ops [10];
        int          kind;
        int          first_st;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [3:0]  code;
        logic [11:0] imm;
        // bit 3 is the alternate form, low bits are funct3
        ops = '{4'h0, 4'h8, 4'h1, 4'h2, 4'h3, 4'h4, 4'h5, 4'hd, 4'h6, 4'h7};
        prog_len = 0;
        exec_est = 0;
        st_addr  = 512;
        // random operands in x1..x8
        for (int r = 1; r <= 8; r++) begin
            emit(u_type(20'($random(seed)), 5'(r), opc_lui));
            emit(i_type(12'($random(seed)), 5'(r), 3'b000, 5'(r), opc_op_imm));
        end
        first_st = st_addr;
        // random alu mix, each result stored
        repeat (24) begin
            kind = $unsigned($random(seed)) % 19;
            rd   = 5'($unsigned($random(seed)) % 16);
            rs1  = 5'($unsigned($random(seed)) % 16);
            rs2  = 5'($unsigned($random(seed)) % 16);
            if (kind < 10) begin
                code = ops[kind];
                emit(r_type(code[2:0], code[3], rd, rs1, rs2));
            end else begin
                // no subi, so skip entry 1
                code = ops[kind == 10 ? 0 : kind - 9];
                imm  = 12'($random(seed));
                if (code[1:0] == 2'b01) begin
                    imm = {1'b0, code[3], 5'b0, imm[4:0]};
                end
                emit(i_type(imm, rs1, code[2:0], rd, opc_op_imm));
            end
            store_word(rd);
        end
        // x0 write is dropped
        emit(i_type(12'd5, 5'd1, 3'b000, 5'd0, opc_op_imm));
        store_word(5'd0);
        // load back the first result
        emit(i_type(12'(first_st), 5'd0, 3'b010, 5'd16, opc_load));
        store_word(5'd16);
        emit(u_type(20'($random(seed)), 5'd17, opc_auipc));
        store_word(5'd17);
        // jal over one addi, link kept
        emit(j_type(21'd8, 5'd18));
        emit(i_type(12'd1, 5'd0, 3'b000, 5'd18, opc_op_imm));
        store_word(5'd18);
        // bne loop, three passes
        emit(i_type(12'd3, 5'd0, 3'b000, 5'd20, opc_op_imm));
        emit(i_type(12'hfff, 5'd20, 3'b000, 5'd20, opc_op_imm));
        store_word(5'd20);
        emit(b_type(13'h1ff8, 5'd20, 5'd0, 3'b001));
        exec_est += 6;
        // beq taken, then most likely not taken
        emit(b_type(13'd8, 5'd1, 5'd1, 3'b000));
        emit(i_type(12'd1, 5'd0, 3'b000, 5'd21, opc_op_imm));
        store_word(5'd21);
        emit(b_type(13'd8, 5'd1, 5'd2, 3'b000));
        emit(i_type(12'd1, 5'd0, 3'b000, 5'd22, opc_op_imm));
        store_word(5'd22);
        // final jal-to-self
        final_pc = 32'(prog_len * 4);
        emit(j_type(21'd0, 5'd0));
    endtask

    // integer op rules by funct3
    function automatic logic [XLEN-1:0] alu_result_of(input logic [2:0] f3, input logic alt,
                                                      input logic [XLEN-1:0] a,
                                                      input logic [XLEN-1:0] b);
        case (f3)
            3'b000:  return alt ? a - b : a + b;
            3'b001:  return a << b[4:0];
            3'b010:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'b011:  return (a < b) ? 32'd1 : 32'd0;
            3'b100:  return a ^ b;
            3'b101:  return alt ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'b110:  return a | b;
            default: return a & b;
        endcase
    endfunction

    // one instruction from model state
    // returns {iaddr, d_rw, daddr, ddata_w}, commit happens later
    function automatic logic [EXP_WIDTH-1:0] step_model();
        logic [31:0]     w;
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] b;
        logic [XLEN-1:0] imm_i;
        logic [XLEN-1:0] addr;
        w     = imem[m_pc[ADDR_WIDTH+1:2]];
        a     = m_reg[w[19:15]];
        b     = m_reg[w[24:20]];
        imm_i = {{20{w[31]}}, w[31:20]};
        nxt_pc    = m_pc + 4;
        nxt_rd    = w[11:7];
        nxt_wr    = 1'b0;
        nxt_val   = '0;
        nxt_st    = 1'b0;
        addr      = '0;
        addr_used = 1'b0;
        case (w[6:0])
            opc_op: begin
                nxt_wr  = 1'b1;
                nxt_val = alu_result_of(w[14:12], w[30], a, b);
            end
            opc_op_imm: begin
                // bit 30 only matters for srai
                nxt_wr  = 1'b1;
                nxt_val = alu_result_of(w[14:12], w[30] && w[14:12] == 3'b101, a, imm_i);
            end
            opc_load: begin
                addr      = a + imm_i;
                addr_used = 1'b1;
                nxt_wr    = 1'b1;
                nxt_val   = m_dmem[addr[ADDR_WIDTH+1:2]];
            end
            opc_store: begin
                addr      = a + {{20{w[31]}}, w[31:25], w[11:7]};
                addr_used = 1'b1;
                nxt_st    = 1'b1;
            end
            opc_branch: begin
                // funct3 bit 0 inverts the equal test
                if ((a == b) != w[12]) begin
                    nxt_pc = m_pc + {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
                end
            end
            opc_lui: begin
                nxt_wr  = 1'b1;
                nxt_val = {w[31:12], 12'b0};
            end
            opc_auipc: begin
                nxt_wr  = 1'b1;
                nxt_val = m_pc + {w[31:12], 12'b0};
            end
            opc_jal: begin
                nxt_wr  = 1'b1;
                nxt_val = m_pc + 4;
                nxt_pc  = m_pc + {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
            end
            default: begin
                nxt_wr = 1'b0;
            end
        endcase
        st_word = addr[ADDR_WIDTH+1:2];
        st_data = b;
        return {m_pc[ADDR_WIDTH+1:2], nxt_st, addr[ADDR_WIDTH+1:2], b};
    endfunction

    task automatic check_output(input string name, input logic [XLEN-1:0] got,
                                input logic [XLEN-1:0] exp);
        if (got !== exp) begin
            $display("FAIL time %0t signal %s got %h expected %h", $time, name, got, exp);
            $display("SIMULATION FAILED");
            $fatal(1, "output mismatch");
        end
    endtask

    // compare on the falling edge, outputs settled
    always @(negedge CLK) begin
        logic [EXP_WIDTH-1:0] exp;
        if (rf_fails != 0) begin
            $display("a register file assertion failed at time %0t", $time);
            $display("SIMULATION FAILED");
            $fatal(1, "assertion failure");
        end
        if (RESET_N) begin
            exp = step_model();
            check_output("iaddr", XLEN'(iaddr), XLEN'(exp[EXP_WIDTH-1 -: ADDR_WIDTH]));
            check_output("d_rw", XLEN'(d_rw), XLEN'(exp[ADDR_WIDTH+XLEN]));
            if (addr_used) begin
                check_output("daddr", XLEN'(daddr), XLEN'(exp[XLEN +: ADDR_WIDTH]));
            end
            if (nxt_st) begin
                check_output("ddata_w", ddata_w, exp[XLEN-1:0]);
            end
            have_step = 1'b1;
            if (m_pc == final_pc) begin
                done = 1'b1;
            end
        end
    end

    // model commits with the DUT
    always @(posedge CLK) begin
        if (have_step) begin
            m_pc = nxt_pc;
            if (nxt_wr && nxt_rd != 5'd0) begin
                m_reg[nxt_rd] = nxt_val;
            end
            if (nxt_st) begin
                m_dmem[st_word] = st_data;
            end
            have_step = 1'b0;
        end
    end

    initial begin
        seed      = 89291;
        RESET_N   = 1'b0;
        done      = 1'b0;
        have_step = 1'b0;
        cycles    = 0;
        for (int i = 0; i < DEPTH; i++) begin
            imem[i]   = '0;
            dmem[i]   = fill_word(i);
            m_dmem[i] = fill_word(i);
        end
        for (int r = 0; r < 32; r++) begin
            m_reg[r] = '0;
        end
        m_pc = '0;
        build_program();
        // four cycles per executed instruction
        limit = 4 * exec_est + RESET_CYCLES;
        repeat (RESET_CYCLES) @(posedge CLK);
        RESET_N <= 1'b1;
        while (!done && cycles < limit) begin
            @(posedge CLK);
            cycles++;
        end
        if (done && rf_fails == 0) begin
            $display("SIMULATION PASSED");
            $finish;
        end else begin
            if (!done) begin
                $display("timeout: program did not reach its final loop in %0d cycles", limit);
            end else begin
                $display("a register file assertion failed near the end of the program");
            end
            $display("SIMULATION FAILED");
            $fatal(1, "run failed");
        end
    end

endmodule

//--- filelist.f
design/rv_pkg.sv
design/instr_decoder.sv
design/register_file.sv
design/alu.sv
design/pc_unit.sv
design/rv_core.sv
tests/register_file_assertions.sv
tests/tb_rv_core.sv

//--- Bender.yml
package:
  name: rv_core

sources:
  - files:
      - design/rv_pkg.sv
      - design/instr_decoder.sv
      - design/register_file.sv
      - design/alu.sv
      - design/pc_unit.sv
      - design/rv_core.sv
  - target: test
    files:
      - tests/register_file_assertions.sv
      - tests/tb_rv_core.sv
